// File: verilog/lcd_defines.svh
`ifndef LCD_DEFINES_SVH
`define LCD_DEFINES_SVH

// tiny frame so a whole picture fits in a short sim
`define H_ACTIVE 16
`define V_ACTIVE 8

// horizontal blanking, in pixel enables
`define H_FRONT 2
`define H_SYNC  1
`define H_BACK  2

// vertical blanking, in lines
`define V_FRONT 1
`define V_SYNC  1
`define V_BACK  1

`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// 2 clocks per lcd spi bit x 16 bits per pixel
`define PIX_DIV 32

// panel reset pulse after system reset
`define LCD_RESET_CYCLES 64

// memory write, opens every frame
`define CMD_RAMWR 8'h2C

`endif

// File: verilog/video_pkg.sv
package video_pkg;

  // one pixel slot of the video stream
  typedef struct packed {
    logic        ena;    // high one clock per pixel
    logic        blank;
    logic        hsync;
    logic        vsync;
    logic [7:0]  x;      // active area coords
    logic [7:0]  y;
    logic [15:0] rgb;    // rgb565
  } video_t;

  // character write word
  typedef struct packed {
    logic       sel;     // 0
    logic [6:0] addr;    // cell index
    logic [7:0] code;
  } osd_wr_t;

  // osd control word
  typedef struct packed {
    logic        sel;      // 1
    logic [13:0] reserved;
    logic        on;
  } osd_ctl_t;

  // one 16 bit spi word, msb selects the decode
  typedef union packed {
    osd_wr_t  wr;
    osd_ctl_t ctl;
  } osd_word_u;

endpackage

// File: verilog/video_timing.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module video_timing (
  input  logic              i_clk_pixel,
  input  logic              i_rst_n,
  output video_pkg::video_t o_video
);

  localparam int DIV_W = $clog2(`PIX_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PIX_DIV - 1);
  localparam logic [7:0] H_LAST = 8'(`H_TOTAL - 1);
  localparam logic [7:0] V_LAST = 8'(`V_TOTAL - 1);
  localparam logic [7:0] H_ACT = 8'(`H_ACTIVE);
  localparam logic [7:0] V_ACT = 8'(`V_ACTIVE);
  localparam logic [7:0] HS_BEGIN = 8'(`H_ACTIVE + `H_FRONT);
  localparam logic [7:0] HS_END = 8'(`H_ACTIVE + `H_FRONT + `H_SYNC);
  localparam logic [7:0] VS_BEGIN = 8'(`V_ACTIVE + `V_FRONT);
  localparam logic [7:0] VS_END = 8'(`V_ACTIVE + `V_FRONT + `V_SYNC);

  logic [DIV_W-1:0] div_cnt;
  logic             pix_tick;
  logic [7:0]       h_cnt;
  logic [7:0]       v_cnt;
  logic             active;

  assign pix_tick = (div_cnt == DIV_LAST);
  assign active = (h_cnt < H_ACT) && (v_cnt < V_ACT);

  // slow pixel enable
  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= pix_tick ? '0 : div_cnt + 1'b1;
    end
  end

  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (pix_tick) begin
      if (h_cnt == H_LAST) begin
        h_cnt <= '0;
        v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1; // next line
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // stream carries the counters as they were at the tick
  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_video <= '0;
    end else begin
      o_video.ena   <= pix_tick;
      o_video.blank <= !active;
      o_video.hsync <= (h_cnt >= HS_BEGIN) && (h_cnt < HS_END);
      o_video.vsync <= (v_cnt >= VS_BEGIN) && (v_cnt < VS_END);
      o_video.x     <= active ? h_cnt : '0;
      o_video.y     <= active ? v_cnt : '0;
      o_video.rgb   <= '0;  // filled by the picture stage
    end
  end

  // downstream stages count every ena as a pixel slot
  a_ena_single : assert property (
    @(posedge i_clk_pixel) disable iff (!i_rst_n)
    o_video.ena |=> !o_video.ena
  );

endmodule

// File: verilog/test_picture.sv
`timescale 1ns/1ps

module test_picture (
  input  logic              i_clk_pixel,
  input  logic              i_rst_n,
  input  video_pkg::video_t i_video,
  output video_pkg::video_t o_video
);

  logic [4:0]  red;
  logic [5:0]  green;
  logic [4:0]  blue;
  logic [15:0] pic_rgb;

  // colour straight from position
  assign red   = i_video.x[4:0];
  assign green = {i_video.y[2:0], i_video.x[2:0]};
  assign blue  = i_video.x[4:0] ^ i_video.y[4:0];  // checker-ish pattern

  assign pic_rgb = {red, green, blue};

  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_video <= '0;
    end else begin
      o_video     <= i_video;
      o_video.rgb <= i_video.blank ? '0 : pic_rgb;  // black in blanking
    end
  end

endmodule

// File: verilog/osd_spi_slave.sv
`timescale 1ns/1ps

module osd_spi_slave (
  input  logic                 i_clk_pixel,
  input  logic                 i_rst_n,
  input  logic                 i_csn,
  input  logic                 i_sclk,
  input  logic                 i_mosi,
  output video_pkg::osd_word_u o_word,
  output logic                 o_word_valid
);

  logic [1:0]  csn_sync;
  logic [1:0]  sclk_sync;
  logic [1:0]  mosi_sync;
  logic        csn_q;
  logic        sclk_q;
  logic        sclk_rise;
  logic        csn_rise;
  logic [4:0]  bit_cnt;
  logic [15:0] shift_q;

  // all three lines take the same delay so mosi lines up with sclk
  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      csn_sync  <= 2'b11;
      sclk_sync <= 2'b00;
      mosi_sync <= 2'b00;
      csn_q     <= 1'b1;
      sclk_q    <= 1'b0;
    end else begin
      csn_sync  <= {csn_sync[0], i_csn};
      sclk_sync <= {sclk_sync[0], i_sclk};
      mosi_sync <= {mosi_sync[0], i_mosi};
      csn_q     <= csn_sync[1];
      sclk_q    <= sclk_sync[1];
    end
  end

  assign sclk_rise = sclk_sync[1] && !sclk_q && !csn_sync[1];  // mode 0 sample
  assign csn_rise  = csn_sync[1] && !csn_q;

  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      bit_cnt      <= '0;
      o_word_valid <= 1'b0;
    end else begin
      o_word_valid <= csn_rise && (bit_cnt == 5'd16);  // other lengths dropped
      if (csn_sync[1]) begin
        bit_cnt <= '0;
      end else if (sclk_rise && bit_cnt != 5'd31) begin
        bit_cnt <= bit_cnt + 1'b1;  // saturates on long frames
      end
    end
  end

  // msb first
  always_ff @(posedge i_clk_pixel) begin
    if (sclk_rise) begin
      shift_q <= {shift_q[14:0], mosi_sync[1]};
    end
    if (csn_rise) begin
      o_word <= shift_q;
    end
  end

  a_valid_pulse : assert property (
    @(posedge i_clk_pixel) disable iff (!i_rst_n)
    o_word_valid |=> !o_word_valid
  );

endmodule

// File: verilog/osd_overlay.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module osd_overlay (
  input  logic                 i_clk_pixel,
  input  logic                 i_rst_n,
  input  video_pkg::osd_word_u i_word,
  input  logic                 i_word_valid,
  input  video_pkg::video_t    i_video,
  output video_pkg::video_t    o_video
);

  localparam int CELLS_X = `H_ACTIVE / 8;  // 8x8 cells

  logic [7:0] char_ram [16];
  logic       osd_on;
  logic [3:0] cell_idx;
  logic [7:0] cell_code;
  logic       pix_on;

  // row * cells per row + column
  assign cell_idx  = 4'((i_video.y >> 3) * CELLS_X + (i_video.x >> 3));
  assign cell_code = char_ram[cell_idx];

  // code drawn as a bar pattern, msb at the left edge of the cell
  assign pix_on = osd_on && !i_video.blank && cell_code[~i_video.x[2:0]];

  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 16; i++) begin
        char_ram[i] <= '0;
      end
      osd_on <= 1'b1;  // osd shown from power up
    end else if (i_word_valid) begin
      if (!i_word.wr.sel) begin
        char_ram[i_word.wr.addr[3:0]] <= i_word.wr.code;
      end else begin
        osd_on <= i_word.ctl.on;
      end
    end
  end

  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_video <= '0;
    end else begin
      o_video <= i_video;
      if (pix_on) begin
        o_video.rgb <= ~i_video.rgb;  // inverse video
      end
    end
  end

endmodule

// File: verilog/lcd_spi_tx.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module lcd_spi_tx (
  input  logic              i_clk_pixel,
  input  logic              i_rst_n,
  input  video_pkg::video_t i_video,
  output logic              o_lcd_resn,
  output logic              o_lcd_clk,
  output logic              o_lcd_dc,
  output logic              o_lcd_mosi
);

  localparam int RST_W = $clog2(`LCD_RESET_CYCLES);
  localparam logic [RST_W-1:0] RST_LAST = RST_W'(`LCD_RESET_CYCLES - 1);
  localparam logic [7:0] CMD = `CMD_RAMWR;

  logic [RST_W-1:0] rst_cnt;
  logic             vs_q;
  logic             vs_start;
  logic             armed;
  logic             load_cmd;
  logic             load_pix;
  logic [15:0]      load_word;
  logic             busy;
  logic [3:0]       bits_left;
  logic [15:0]      shift_q;

  // panel reset pulse
  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rst_cnt    <= '0;
      o_lcd_resn <= 1'b0;
    end else if (!o_lcd_resn) begin
      if (rst_cnt == RST_LAST) begin
        o_lcd_resn <= 1'b1;
      end else begin
        rst_cnt <= rst_cnt + 1'b1;
      end
    end
  end

  assign vs_start = i_video.ena && i_video.vsync && !vs_q;

  // command byte on every vsync once the panel is out of reset
  assign load_cmd = o_lcd_resn && vs_start;
  assign load_pix = o_lcd_resn && armed && i_video.ena && !i_video.blank;

  assign load_word = load_cmd ? {CMD, 8'h00} : i_video.rgb;

  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      vs_q  <= 1'b0;
      armed <= 1'b0;
    end else begin
      if (i_video.ena) begin
        vs_q <= i_video.vsync;
      end
      if (load_cmd) begin
        armed <= 1'b1;  // stays armed, streams every frame
      end
    end
  end

  // two clocks per bit, clk low while data changes
  always_ff @(posedge i_clk_pixel or negedge i_rst_n) begin
    if (!i_rst_n) begin
      busy       <= 1'b0;
      bits_left  <= '0;
      o_lcd_clk  <= 1'b1;  // idle high
      o_lcd_dc   <= 1'b0;
      o_lcd_mosi <= 1'b0;
    end else if (load_cmd || load_pix) begin
      busy       <= 1'b1;
      bits_left  <= load_cmd ? 4'd7 : 4'd15;
      o_lcd_dc   <= load_pix;
      o_lcd_clk  <= 1'b0;
      o_lcd_mosi <= load_word[15];
    end else if (busy) begin
      if (!o_lcd_clk) begin
        o_lcd_clk <= 1'b1;  // panel samples here
        if (bits_left == 4'd0) begin
          busy <= 1'b0;  // last high phase ends on the next ena
        end
      end else begin
        o_lcd_clk  <= 1'b0;
        o_lcd_mosi <= shift_q[15];
        bits_left  <= bits_left - 1'b1;
      end
    end
  end

  // remaining bits after the one on mosi
  always_ff @(posedge i_clk_pixel) begin
    if (load_cmd || load_pix) begin
      shift_q <= {load_word[14:0], 1'b0};
    end else if (busy && o_lcd_clk) begin
      shift_q <= {shift_q[14:0], 1'b0};
    end
  end

  // pixel rate and PIX_DIV must leave room for the full word
  a_no_overrun : assert property (
    @(posedge i_clk_pixel) disable iff (!i_rst_n)
    (load_cmd || load_pix) |-> !busy
  );

endmodule

// File: verilog/lcd_osd_top.sv
`timescale 1ns/1ps

module lcd_osd_top (
  input  logic i_clk_pixel,
  input  logic i_rst_n,
  input  logic i_osd_csn,
  input  logic i_osd_sclk,
  input  logic i_osd_mosi,
  output logic o_lcd_csn,
  output logic o_lcd_resn,
  output logic o_lcd_clk,
  output logic o_lcd_dc,
  output logic o_lcd_mosi
);

  import video_pkg::*;

  video_t    tim_v;
  video_t    pic_v;
  video_t    osd_v;
  osd_word_u osd_word;
  logic      osd_word_valid;

  video_timing timing0 (
    .i_clk_pixel (i_clk_pixel),
    .i_rst_n     (i_rst_n),
    .o_video     (tim_v)
  );

  test_picture picture0 (
    .i_clk_pixel (i_clk_pixel),
    .i_rst_n     (i_rst_n),
    .i_video     (tim_v),
    .o_video     (pic_v)
  );

  // osd words from the external spi link
  osd_spi_slave osd_rx0 (
    .i_clk_pixel  (i_clk_pixel),
    .i_rst_n      (i_rst_n),
    .i_csn        (i_osd_csn),
    .i_sclk       (i_osd_sclk),
    .i_mosi       (i_osd_mosi),
    .o_word       (osd_word),
    .o_word_valid (osd_word_valid)
  );

  osd_overlay overlay0 (
    .i_clk_pixel  (i_clk_pixel),
    .i_rst_n      (i_rst_n),
    .i_word       (osd_word),
    .i_word_valid (osd_word_valid),
    .i_video      (pic_v),
    .o_video      (osd_v)
  );

  lcd_spi_tx lcd_tx0 (
    .i_clk_pixel (i_clk_pixel),
    .i_rst_n     (i_rst_n),
    .i_video     (osd_v),
    .o_lcd_resn  (o_lcd_resn),
    .o_lcd_clk   (o_lcd_clk),
    .o_lcd_dc    (o_lcd_dc),
    .o_lcd_mosi  (o_lcd_mosi)
  );

  assign o_lcd_csn = 1'b1;  // 7-pin panel, no chip select

endmodule

// File: dv/tb_lcd_osd.sv
`timescale 1ns/1ps
`include "lcd_defines.svh"

module tb_lcd_osd;

  import video_pkg::*;

  localparam int FRAME_CLKS = `PIX_DIV * `H_TOTAL * `V_TOTAL * 2;
  localparam int PIXELS = `H_ACTIVE * `V_ACTIVE;

  logic clk;
  logic rst_n;
  logic osd_csn;
  logic osd_sclk;
  logic osd_mosi;
  wire  lcd_csn;
  wire  lcd_resn;
  wire  lcd_clk;
  wire  lcd_dc;
  wire  lcd_mosi;

  logic [7:0]  ref_ram [16];  // model of the character ram
  logic        ref_on;
  logic [16:0] bus_q[$];      // {dc, data} in bus order
  logic [15:0] mon_shift;
  int          mon_bits;

  lcd_osd_top dut0 (
    .i_clk_pixel (clk),
    .i_rst_n     (rst_n),
    .i_osd_csn   (osd_csn),
    .i_osd_sclk  (osd_sclk),
    .i_osd_mosi  (osd_mosi),
    .o_lcd_csn   (lcd_csn),
    .o_lcd_resn  (lcd_resn),
    .o_lcd_clk   (lcd_clk),
    .o_lcd_dc    (lcd_dc),
    .o_lcd_mosi  (lcd_mosi)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // inputs move just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail t=%0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_cmd(input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Fail t=%0t o_lcd_mosi command expected %h actual %h", $time, exp, act);
      abort_run();
    end
  endtask

  task automatic check_pixel(input video_t exp_v, input video_t act_v);
    if (act_v.rgb !== exp_v.rgb) begin
      $display("Fail t=%0t o_lcd_mosi pixel x=%0d y=%0d expected %h actual %h",
               $time, exp_v.x, exp_v.y, exp_v.rgb, act_v.rgb);
      abort_run();
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      $display("Fail t=%0t %s expected %0d actual %0d", $time, name, exp, act);
      abort_run();
    end
  endtask

  // picture rule and then the bar pattern of the 8x8 cell
  function automatic video_t expected_pixel(input logic [7:0] x, input logic [7:0] y,
                                            input logic use_osd);
    video_t     v;
    logic [7:0] code;
    logic [2:0] bit_sel;
    v = '0;
    v.x = x;
    v.y = y;
    v.rgb = {x[4:0], y[2:0], x[2:0], x[4:0] ^ y[4:0]};
    code = ref_ram[4'((y / 8) * (`H_ACTIVE / 8) + x / 8)];
    bit_sel = 3'(7 - x % 8);  // msb at the left edge
    if (use_osd && code[bit_sel]) begin
      v.rgb = ~v.rgb;
    end
    return v;
  endfunction

  // panel samples mosi on the rising lcd clock
  always @(posedge lcd_clk) begin
    if (rst_n && lcd_resn) begin
      mon_shift = {mon_shift[14:0], lcd_mosi};
      mon_bits  = mon_bits + 1;
      if (!lcd_dc && mon_bits == 8) begin
        bus_q.push_back({1'b0, 8'h00, mon_shift[7:0]});
        mon_bits = 0;
      end else if (lcd_dc && mon_bits == 16) begin
        bus_q.push_back({1'b1, mon_shift});
        mon_bits = 0;
      end
    end
  end

  task automatic next_bus_word(output logic [16:0] item);
    int n;
    n = 0;
    item = '0;
    while (bus_q.size() == 0 && n < FRAME_CLKS) begin
      tick();
      n++;
    end
    if (bus_q.size() == 0) begin
      $display("no word on the LCD bus within %0d clocks", FRAME_CLKS);
      abort_run();
    end else begin
      item = bus_q.pop_front();
    end
  endtask

  // mode 0 with sclk toggling every 6 clocks
  task automatic send_osd_word(input osd_word_u word, input int nbits);
    logic [15:0] bits;
    bits = word;
    osd_csn = 1'b0;
    for (int i = 0; i < nbits; i++) begin
      osd_mosi = bits[15];
      bits = bits << 1;
      repeat (6) tick();
      osd_sclk = 1'b1;
      repeat (6) tick();
      osd_sclk = 1'b0;
    end
    repeat (6) tick();
    osd_csn  = 1'b1;
    osd_mosi = 1'b0;
  endtask

  task automatic wait_word(input logic expect_word);
    logic seen;
    seen = 1'b0;
    for (int n = 0; n < 16 && !seen; n++) begin
      tick();
      seen = dut0.osd_word_valid;
    end
    if (seen !== expect_word) begin
      $display("OSD receiver %s a word after the SPI frame",
               expect_word ? "did not deliver" : "wrongly delivered");
      abort_run();
    end
  endtask

  // no pixel may reach the panel before the first frame command
  task automatic check_first_word();
    logic [16:0] item;
    next_bus_word(item);
    check_level("o_lcd_dc", 1'b0, item[16]);
    check_cmd(`CMD_RAMWR, item[7:0]);
  endtask

  task automatic check_frame(input int exp_inverted);
    logic [16:0] item;
    video_t      exp_v;
    video_t      act_v;
    video_t      plain_v;
    int          n_inv;
    n_inv = 0;
    bus_q.delete();
    next_bus_word(item);
    // drop the tail of a frame already in flight
    for (int k = 0; k < PIXELS && item[16]; k++) begin
      next_bus_word(item);
    end
    check_level("o_lcd_dc", 1'b0, item[16]);
    check_cmd(`CMD_RAMWR, item[7:0]);
    for (int y = 0; y < `V_ACTIVE; y++) begin
      for (int x = 0; x < `H_ACTIVE; x++) begin
        next_bus_word(item);
        check_level("o_lcd_dc", 1'b1, item[16]);
        exp_v   = expected_pixel(8'(x), 8'(y), ref_on);
        plain_v = expected_pixel(8'(x), 8'(y), 1'b0);
        act_v     = exp_v;
        act_v.rgb = item[15:0];
        check_pixel(exp_v, act_v);
        if (act_v.rgb != plain_v.rgb) begin
          n_inv++;
        end
      end
    end
    next_bus_word(item);  // must be the next frame's command
    check_level("o_lcd_dc", 1'b0, item[16]);
    check_cmd(`CMD_RAMWR, item[7:0]);
    check_count("inverted pixels", exp_inverted, n_inv);
  endtask

  task automatic run_stimulus();
    int          fd;
    int          rc;
    int          arg;
    int          short_flag;
    logic [7:0]  tag;
    logic [7:0]  addr;
    logic [7:0]  code;
    osd_word_u   word;
    fd = $fopen("dv/osd_stimulus.txt", "r");
    if (fd == 0) begin
      $display("cannot open dv/osd_stimulus.txt");
      abort_run();
    end else begin
      rc = $fscanf(fd, " %c", tag);
      while (rc == 1) begin
        word = '0;
        if (tag == "W") begin
          rc = $fscanf(fd, " %h %h %d", addr, code, short_flag);
          word.wr.addr = addr[6:0];
          word.wr.code = code;
          if (short_flag == 0) begin
            ref_ram[addr[3:0]] = code;
          end
          send_osd_word(word, (short_flag != 0) ? 12 : 16);
          wait_word(short_flag == 0);
        end else if (tag == "C") begin
          rc = $fscanf(fd, " %d", arg);
          word.ctl.sel = 1'b1;
          word.ctl.on  = (arg != 0);
          ref_on = (arg != 0);
          send_osd_word(word, 16);
          wait_word(1'b1);
        end else if (tag == "F") begin
          rc = $fscanf(fd, " %d", arg);
          check_frame(arg);
        end
        rc = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
    end
  endtask

  // panel reset must last the full count from reset release
  task automatic wait_resn();
    int n;
    n = 0;
    while (!lcd_resn && n < 2 * `LCD_RESET_CYCLES) begin
      tick();
      n++;
    end
    if (!lcd_resn) begin
      $display("o_lcd_resn stayed low after reset");
      abort_run();
    end else begin
      check_count("o_lcd_resn low clocks", `LCD_RESET_CYCLES, n);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    osd_csn   = 1'b1;
    osd_sclk  = 1'b0;
    osd_mosi  = 1'b0;
    mon_bits  = 0;
    mon_shift = '0;
    ref_on    = 1'b1;
    for (int i = 0; i < 16; i++) begin
      ref_ram[i] = '0;
    end
    repeat (5) tick();
    check_level("o_lcd_resn", 1'b0, lcd_resn);
    check_level("o_lcd_clk", 1'b1, lcd_clk);
    check_level("o_lcd_csn", 1'b1, lcd_csn);
    check_level("o_lcd_dc", 1'b0, lcd_dc);
    check_level("o_lcd_mosi", 1'b0, lcd_mosi);
    rst_n = 1'b1;
    wait_resn();
    check_first_word();
    run_stimulus();
    $display("Test passed");
    $finish;
  end

endmodule

// File: dv/osd_stimulus.txt
F 0
W 01 3c 0
F 32
W 00 81 0
W 05 ff 0
F 48
C 0
F 0
C 1
F 48
W 01 ff 1
F 48
W 00 00 0
F 32

// File: list.f
+incdir+verilog
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/test_picture.sv
verilog/osd_spi_slave.sv
verilog/osd_overlay.sv
verilog/lcd_spi_tx.sv
verilog/lcd_osd_top.sv
dv/tb_lcd_osd.sv

// File: Makefile
TOP = tb_lcd_osd

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir
